// ==== source/des_pkg.sv ====
`default_nettype none

package des_pkg;

    // widths
    localparam int block_w      = 64;
    localparam int half_w       = 32;
    localparam int key_w        = 64;  // parity bits included
    localparam int cd_w         = 28;
    localparam int subkey_w     = 48;
    localparam int num_rounds   = 16;
    localparam int num_sboxes   = 8;
    localparam int pipe_latency = 18;  // input stage + 16 rounds + output stage

    // all tables 1-based, counted from the msb as in FIPS 46
    localparam int ip_table [block_w] = '{
        58, 50, 42, 34, 26, 18, 10, 2,
        60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6,
        64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9,  1,
        59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5,
        63, 55, 47, 39, 31, 23, 15, 7
    };

    // inverse of ip
    localparam int fp_table [block_w] = '{
        40, 8, 48, 16, 56, 24, 64, 32,
        39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30,
        37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28,
        35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26,
        33, 1, 41, 9,  49, 17, 57, 25
    };

    // drops the parity bits, first 28 entries form c
    localparam int pc1_table [2*cd_w] = '{
        57, 49, 41, 33, 25, 17, 9,
        1,  58, 50, 42, 34, 26, 18,
        10, 2,  59, 51, 43, 35, 27,
        19, 11, 3,  60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
        7,  62, 54, 46, 38, 30, 22,
        14, 6,  61, 53, 45, 37, 29,
        21, 13, 5,  28, 20, 12, 4
    };

    localparam int pc2_table [subkey_w] = '{
        14, 17, 11, 24, 1,  5,
        3,  28, 15, 6,  21, 10,
        23, 19, 12, 4,  26, 8,
        16, 7,  27, 20, 13, 2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    // expansion of the right half, 32 -> 48
    localparam int e_table [subkey_w] = '{
        32, 1,  2,  3,  4,  5,
        4,  5,  6,  7,  8,  9,
        8,  9,  10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32, 1
    };

    localparam int p_table [half_w] = '{
        16, 7,  20, 21, 29, 12, 28, 17,
        1,  15, 23, 26, 5,  18, 31, 10,
        2,  8,  24, 14, 32, 27, 3,  9,
        19, 13, 30, 6,  22, 11, 4,  25
    };

    // left rotate amount per round
    localparam int shift_table [num_rounds] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // [box][row][column]
    localparam logic [3:0] sbox_table [num_sboxes][4][16] = '{
        '{'{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7},   // s1
          '{0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8},
          '{4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0},
          '{15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13}},
        '{'{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10},   // s2
          '{3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5},
          '{0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15},
          '{13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9}},
        '{'{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8},   // s3
          '{13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1},
          '{13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7},
          '{1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12}},
        '{'{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15},   // s4
          '{13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9},
          '{10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4},
          '{3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14}},
        '{'{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9},   // s5
          '{14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6},
          '{4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14},
          '{11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3}},
        '{'{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11},   // s6
          '{10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8},
          '{9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6},
          '{4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13}},
        '{'{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1},   // s7
          '{13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6},
          '{1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2},
          '{6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12}},
        '{'{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7},   // s8
          '{1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2},
          '{7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8},
          '{2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}}
    };

    typedef logic [block_w-1:0] des_block_t;

    typedef struct packed {
        logic [half_w-1:0] left;
        logic [half_w-1:0] right;
    } des_halves_t;

    // permutations see a word, rounds see two halves
    typedef union packed {
        des_block_t  raw;
        des_halves_t halves;
    } des_block_u;

    typedef struct packed {
        logic [cd_w-1:0] c;
        logic [cd_w-1:0] d;
    } key_halves_t;

    // bundle handed from stage to stage
    typedef struct packed {
        logic        valid;
        des_block_u  block;
        key_halves_t key;
    } round_state_t;

endpackage

`default_nettype wire

// ==== source/des_input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_input_stage (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  in_valid,
    input  wire des_pkg::des_block_t   key,
    input  wire des_pkg::des_block_t   value,
    output des_pkg::round_state_t      stage_out
);

    des_pkg::des_block_u   ip_block;  // value after initial permutation
    des_pkg::key_halves_t  cd_key;    // key after pc-1, {c0, d0}

    always_comb
    begin
        for (int i = 0; i < des_pkg::block_w; i++)
        begin
            ip_block.raw[des_pkg::block_w-1-i] = value[des_pkg::block_w - des_pkg::ip_table[i]];
        end
        // 64 -> 56, parity bits fall out here
        for (int i = 0; i < 2*des_pkg::cd_w; i++)
        begin
            cd_key[2*des_pkg::cd_w-1-i] = key[des_pkg::key_w - des_pkg::pc1_table[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            stage_out <= '0;
        else
        begin
            stage_out.valid <= in_valid;  // accepted every cycle, no stall
            stage_out.block <= ip_block;
            stage_out.key   <= cd_key;
        end
    end

endmodule

`default_nettype wire

// ==== source/des_feistel.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_feistel (
    input  wire logic [des_pkg::half_w-1:0]   half_in,
    input  wire logic [des_pkg::subkey_w-1:0] subkey,
    output logic [des_pkg::half_w-1:0]        f_out
);

    logic [des_pkg::subkey_w-1:0] e_bits;    // expanded right half
    logic [des_pkg::subkey_w-1:0] mixed;     // E(R) ^ K
    logic [des_pkg::half_w-1:0]   sbox_out;  // eight nibbles, s1 on top

    // expansion, 32 -> 48
    always_comb
    begin
        for (int i = 0; i < des_pkg::subkey_w; i++)
        begin
            e_bits[des_pkg::subkey_w-1-i] = half_in[des_pkg::half_w - des_pkg::e_table[i]];
        end
    end

    assign mixed = e_bits ^ subkey;

    // one 6-bit group per box
    for (genvar s = 0; s < des_pkg::num_sboxes; s++)
    begin : g_sbox
        logic [5:0] grp;

        assign grp = mixed[des_pkg::subkey_w-1-6*s -: 6];
        // row from outer bits, column from inner four
        assign sbox_out[des_pkg::half_w-1-4*s -: 4] =
            des_pkg::sbox_table[s][{grp[5], grp[0]}][grp[4:1]];
    end

    // p permutation
    always_comb
    begin
        for (int i = 0; i < des_pkg::half_w; i++)
        begin
            f_out[des_pkg::half_w-1-i] = sbox_out[des_pkg::half_w - des_pkg::p_table[i]];
        end
    end

endmodule

`default_nettype wire

// ==== source/des_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_round #(
    parameter int round_idx = 0  // 0..15, picks the rotate amount
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire des_pkg::round_state_t  stage_in,
    output des_pkg::round_state_t       stage_out
);

    des_pkg::key_halves_t          key_rot;  // c/d after this round's rotate
    logic [des_pkg::subkey_w-1:0]  subkey;   // K(round_idx+1)
    logic [des_pkg::half_w-1:0]    f_res;

    // circular left shift by 1 or 2
    always_comb
    begin
        key_rot.c = (stage_in.key.c << des_pkg::shift_table[round_idx])
                  | (stage_in.key.c >> (des_pkg::cd_w - des_pkg::shift_table[round_idx]));
        key_rot.d = (stage_in.key.d << des_pkg::shift_table[round_idx])
                  | (stage_in.key.d >> (des_pkg::cd_w - des_pkg::shift_table[round_idx]));
    end

    // pc-2 over {c, d}, 56 -> 48
    always_comb
    begin
        for (int i = 0; i < des_pkg::subkey_w; i++)
        begin
            subkey[des_pkg::subkey_w-1-i] = key_rot[2*des_pkg::cd_w - des_pkg::pc2_table[i]];
        end
    end

    des_feistel u_feistel (
        .half_in (stage_in.block.halves.right),
        .subkey  (subkey),
        .f_out   (f_res)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            stage_out <= '0;
        else
        begin
            stage_out.valid              <= stage_in.valid;
            stage_out.block.halves.left  <= stage_in.block.halves.right;          // L = R
            stage_out.block.halves.right <= stage_in.block.halves.left ^ f_res;  // R = L ^ f
            stage_out.key                <= key_rot;  // next round rotates from here
        end
    end

endmodule

`default_nettype wire

// ==== source/des_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_output_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire des_pkg::round_state_t  stage_in,
    output logic                        out_valid,
    output des_pkg::des_block_t         msg
);

    des_pkg::des_block_t preout;  // R16 L16, halves swapped
    des_pkg::des_block_t fp_out;

    assign preout = {stage_in.block.halves.right, stage_in.block.halves.left};

    // final permutation, inverse of ip
    always_comb
    begin
        for (int i = 0; i < des_pkg::block_w; i++)
        begin
            fp_out[des_pkg::block_w-1-i] = preout[des_pkg::block_w - des_pkg::fp_table[i]];
        end
    end

    // key halves stop at this stage
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            msg       <= '0;
        end
        else
        begin
            out_valid <= stage_in.valid;
            msg       <= fp_out;
        end
    end

endmodule

`default_nettype wire

// ==== source/des_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire des_pkg::des_block_t  key,
    input  wire des_pkg::des_block_t  value,
    output logic                      out_valid,
    output des_pkg::des_block_t       msg
);

    // stage_bus[0] from input stage, stage_bus[16] into output stage
    des_pkg::round_state_t stage_bus [des_pkg::num_rounds+1];

    des_input_stage u_input (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .key       (key),
        .value     (value),
        .stage_out (stage_bus[0])
    );

    // one registered round per stage
    for (genvar r = 0; r < des_pkg::num_rounds; r++)
    begin : g_round
        des_round #(
            .round_idx (r)
        ) u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .stage_in  (stage_bus[r]),
            .stage_out (stage_bus[r+1])
        );
    end

    des_output_stage u_output (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage_in  (stage_bus[des_pkg::num_rounds]),
        .out_valid (out_valid),
        .msg       (msg)
    );

endmodule

`default_nettype wire

// ==== sim/des_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module des_checker (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 in_valid,
    input  wire des_pkg::des_block_t  ref_msg,    // model result for the current key/value
    input  wire logic                 out_valid,
    input  wire des_pkg::des_block_t  msg,
    output logic                      q_empty
);

    typedef struct packed {
        des_pkg::des_block_t exp_msg;
        int                  due;      // checker cycle the result must show up on
    } pending_t;

    pending_t exp_q [$];  // in flight, oldest first
    pending_t head;
    pending_t entry;
    int       cycle;
    int       test_errs;
    int       pass_count;
    int       fail_count;

    initial
    begin
        cycle      = 0;
        test_errs  = 0;
        pass_count = 0;
        fail_count = 0;
        q_empty    = 1'b1;
    end

    task report_failure(input string text);
        $display("%0t: %s", $time, text);
        test_errs++;
    endtask

    task compare_block(input string what, input des_pkg::des_block_t exp,
                       input des_pkg::des_block_t act);
        if (act !== exp)
        begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
            test_errs++;
        end
    endtask

    // one line per test, leftovers count as errors
    task end_test(input string name);
        if (exp_q.size() != 0)
            report_failure($sformatf("%0d results never came out", exp_q.size()));
        exp_q.delete();
        q_empty = 1'b1;
        if (test_errs == 0)
        begin
            pass_count++;
            $display("test %s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAIL with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    always @(posedge clk)
    begin
        cycle++;
        if (!rst_n)
        begin
            if (out_valid === 1'b1)
                report_failure("out_valid high while reset is asserted");
            exp_q.delete();  // blocks in the pipe are dropped
        end
        else
        begin
            if (out_valid === 1'b1)
            begin
                if (exp_q.size() == 0)
                    report_failure("out_valid with no accepted input pending");
                else
                begin
                    head = exp_q.pop_front();
                    if (cycle != head.due)
                        report_failure($sformatf("result at cycle %0d, due at cycle %0d",
                                                 cycle, head.due));
                    if (msg !== head.exp_msg)
                    begin
                        $display("Mismatch at %0t: msg expected %h, got %h",
                                 $time, head.exp_msg, msg);
                        test_errs++;
                    end
                end
            end
            if (in_valid === 1'b1)
            begin
                entry.exp_msg = ref_msg;
                entry.due     = cycle + des_pkg::pipe_latency;
                exp_q.push_back(entry);
            end
        end
        q_empty = (exp_q.size() == 0);  // read by the tb at negedge
    end

endmodule

`default_nettype wire

// ==== sim/tb_des.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_des;

    localparam int drain_cycles = des_pkg::pipe_latency + 4;
    // reset, known, stream, gapped (two cycles a pair at worst), weak key, reset test
    localparam int stim_cycles    = 8 + 1 + 300 + 400 + 40 + 27;
    localparam int timeout_cycles = stim_cycles + 7 * drain_cycles + 100;
    localparam des_pkg::des_block_t weak_key = 64'h0101_0101_0101_0101;

    logic                clk;
    logic                rst_n;
    logic                in_valid;
    des_pkg::des_block_t key;
    des_pkg::des_block_t value;
    logic                out_valid;
    des_pkg::des_block_t msg;
    des_pkg::des_block_t ref_msg;
    logic                q_empty;
    logic [31:0]         rng_state;
    int                  cycle_cnt;
    int                  n_cap;         // outputs grabbed by collect
    des_pkg::des_block_t blk_buf [20];  // weak-key plaintexts
    des_pkg::des_block_t ct_buf  [20];
    des_pkg::des_block_t cap_buf [20];

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // straight FIPS 46 encryption, one round per loop pass
    function automatic des_pkg::des_block_t des_ref(input des_pkg::des_block_t k,
                                                    input des_pkg::des_block_t p);
        logic [63:0] ip;
        logic [55:0] cd;
        logic [27:0] c;
        logic [27:0] d;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] s_out;
        logic [31:0] f;
        logic [31:0] tmp;
        logic [47:0] sk;
        logic [47:0] e;
        logic [5:0]  g;
        logic [63:0] pre;
        logic [63:0] res;
        for (int i = 0; i < 64; i++)
            ip[63-i] = p[64 - des_pkg::ip_table[i]];
        for (int i = 0; i < 56; i++)
            cd[55-i] = k[64 - des_pkg::pc1_table[i]];
        c = cd[55:28];
        d = cd[27:0];
        l = ip[63:32];
        r = ip[31:0];
        for (int rnd = 0; rnd < 16; rnd++)
        begin
            for (int j = 0; j < des_pkg::shift_table[rnd]; j++)
            begin
                c = {c[26:0], c[27]};  // rotate one bit at a time
                d = {d[26:0], d[27]};
            end
            cd = {c, d};
            for (int i = 0; i < 48; i++)
                sk[47-i] = cd[56 - des_pkg::pc2_table[i]];
            for (int i = 0; i < 48; i++)
                e[47-i] = r[32 - des_pkg::e_table[i]];
            e = e ^ sk;
            for (int s = 0; s < 8; s++)
            begin
                g = e[47-6*s -: 6];
                s_out[31-4*s -: 4] = des_pkg::sbox_table[s][{g[5], g[0]}][g[4:1]];
            end
            for (int i = 0; i < 32; i++)
                f[31-i] = s_out[32 - des_pkg::p_table[i]];
            tmp = r;
            r   = l ^ f;
            l   = tmp;
        end
        pre = {r, l};  // undo the last swap
        for (int i = 0; i < 64; i++)
            res[63-i] = pre[64 - des_pkg::fp_table[i]];
        return res;
    endfunction

    assign ref_msg = des_ref(key, value);

    des_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .key       (key),
        .value     (value),
        .out_valid (out_valid),
        .msg       (msg)
    );

    des_checker chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .ref_msg   (ref_msg),
        .out_valid (out_valid),
        .msg       (msg),
        .q_empty   (q_empty)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // run limit, counted in clocks
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
        $display("tests failed");
        $finish;
    end

    task automatic rand64(output des_pkg::des_block_t r);
        rng_state = xorshift32(rng_state);
        r[63:32]  = rng_state;
        rng_state = xorshift32(rng_state);
        r[31:0]   = rng_state;
    endtask

    task automatic drive(input logic v, input des_pkg::des_block_t k,
                         input des_pkg::des_block_t p);
        @(posedge clk);
        in_valid <= v;
        key      <= k;
        value    <= p;
    endtask

    task automatic idle();
        drive(1'b0, key, value);
    endtask

    task automatic drive_random();
        des_pkg::des_block_t k;
        des_pkg::des_block_t p;
        rand64(k);
        rand64(p);
        drive(1'b1, k, p);
    endtask

    // wait until every pending result is out, bounded
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!q_empty && waited < drain_cycles)
        begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic collect(input int n);
        int waited;
        n_cap  = 0;
        waited = 0;
        while (n_cap < n && waited < n + drain_cycles)
        begin
            @(negedge clk);  // msg settled mid-cycle
            waited++;
            if (out_valid)
            begin
                cap_buf[n_cap] = msg;
                n_cap++;
            end
        end
        if (n_cap < n)
            chk_i.report_failure($sformatf("only %0d of %0d outputs arrived", n_cap, n));
    endtask

    initial
    begin
        rng_state = 32'h5270_43f7;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        key       = '0;
        value     = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // textbook vector, model and DUT both
        chk_i.compare_block("des_ref known vector", 64'h85E8_1354_0F0A_B405,
                            des_ref(64'h1334_5779_9BBC_DFF1, 64'h0123_4567_89AB_CDEF));
        drive(1'b1, 64'h1334_5779_9BBC_DFF1, 64'h0123_4567_89AB_CDEF);
        idle();
        collect(1);
        chk_i.compare_block("known vector msg", 64'h85E8_1354_0F0A_B405, cap_buf[0]);
        drain();
        chk_i.end_test("known vector");

        repeat (300)
            drive_random();
        idle();
        drain();
        chk_i.end_test("back-to-back stream");

        repeat (200)
        begin
            rng_state = xorshift32(rng_state);
            if (rng_state[0])
                idle();  // random hole in the strobe
            drive_random();
        end
        idle();
        drain();
        chk_i.end_test("gapped strobe");

        // weak key, encrypting twice gives the block back
        for (int i = 0; i < 20; i++)
            rand64(blk_buf[i]);
        fork
            begin
                for (int i = 0; i < 20; i++)
                    drive(1'b1, weak_key, blk_buf[i]);
                idle();
            end
            collect(20);
        join
        for (int i = 0; i < 20; i++)
            ct_buf[i] = cap_buf[i];
        fork
            begin
                for (int i = 0; i < 20; i++)
                    drive(1'b1, weak_key, ct_buf[i]);
                idle();
            end
            collect(20);
        join
        for (int i = 0; i < 20; i++)
            chk_i.compare_block($sformatf("weak-key round trip %0d", i), blk_buf[i], cap_buf[i]);
        drain();
        chk_i.end_test("weak-key involution");

        repeat (12)
            drive_random();
        @(posedge clk);
        in_valid <= 1'b0;
        rst_n    <= 1'b0;  // pipe still full
        repeat (8) @(posedge clk);  // oldest blocks would reach msg before release
        rst_n <= 1'b1;
        repeat (drain_cycles) @(posedge clk);  // old blocks would surface here
        repeat (5)
            drive_random();
        idle();
        drain();
        chk_i.end_test("reset in flight");

        $display("summary: passed %0d, failed %0d", chk_i.pass_count, chk_i.fail_count);
        if (chk_i.fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
source/des_pkg.sv
source/des_input_stage.sv
source/des_feistel.sv
source/des_round.sv
source/des_output_stage.sv
source/des_top.sv
sim/des_checker.sv
sim/tb_des.sv

// ==== Bender.yml ====
package:
  name: des_pipeline

sources:
  - source/des_pkg.sv
  - source/des_input_stage.sv
  - source/des_feistel.sv
  - source/des_round.sv
  - source/des_output_stage.sv
  - source/des_top.sv
  - target: test
    files:
      - sim/des_checker.sv
      - sim/tb_des.sv
